// File: src/l1_bus_pkg.sv
// Shared widths, source tags and request/response structs for the L1 to Wishbone bridge
package l1_bus_pkg;

    // Byte address and data widths of the L1 ports
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Wishbone carries word addresses, so the two low bits are dropped
    localparam int WB_ADR_W = ADDR_W - 2;

    // One enable per byte lane
    localparam int BE_W = DATA_W / 8;

    // Requester that a transaction belongs to
    typedef enum logic {
        SRC_IFETCH = 1'b0,
        SRC_DATA   = 1'b1
    } l1_source_t;

    // Instruction fetch request, always a full word read
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } ifetch_req_t;

    // Data port request, read or write with byte enables
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] wdata;
    } data_req_t;

    // Arbitrated request towards the bus master
    // Instruction fetches are widened to the data request layout
    typedef struct packed {
        data_req_t  cmd;
        l1_source_t src;
    } l2_req_t;

    // Bus result with the tag of the requester it goes back to
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
        l1_source_t        src;
    } l2_rsp_t;

    // Response as seen by one requester
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } port_rsp_t;

endpackage

// File: src/l1_request_hold.sv
// Per-port hold register that keeps one strobed request until the arbiter takes it
`timescale 1ns/1ns

module l1_request_hold #(
    parameter type REQ_T = logic
) (
    input  logic clk,
    input  logic rst,

    // Requester side
    input  logic req,
    input  REQ_T req_data,
    output logic busy,

    // Arbiter side
    output logic pending,
    output REQ_T held,
    input  logic take,

    // Response pulse from the router ends the transaction
    input  logic rsp_valid
);

    logic accept;

    // A strobe only counts while no transaction is outstanding
    assign accept = req && !busy;

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            pending <= 1'b0;
        end else begin
            // Busy covers hold time and flight time down the pipeline
            if (accept) begin
                busy <= 1'b1;
            end else if (rsp_valid) begin
                busy <= 1'b0;
            end

            if (accept) begin
                pending <= 1'b1;
            end else if (take) begin
                pending <= 1'b0;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (accept) begin
            held <= req_data;
        end
    end

    // Requester must wait for busy to fall
    a_no_req_while_busy : assert property (
        @(posedge clk) disable iff (rst)
        req |-> !busy
    ) else $error("request strobe while busy");

    // Arbiter only takes what is held
    a_take_needs_pending : assert property (
        @(posedge clk) disable iff (rst)
        take |-> pending
    ) else $error("take pulse without a pending request");

endmodule

// File: src/l1_arbiter.sv
// Round-robin arbiter that merges held instruction and data requests into one tagged request
`timescale 1ns/1ns

module l1_arbiter (
    input  logic clk,
    input  logic rst,

    // Instruction fetch hold stage
    input  logic                    if_pending,
    input  l1_bus_pkg::ifetch_req_t if_held,
    output logic                    if_take,

    // Data hold stage
    input  logic                    d_pending,
    input  l1_bus_pkg::data_req_t   d_held,
    output logic                    d_take,

    // Bus master side
    input  logic                    master_idle,
    output logic                    req_valid,
    output l1_bus_pkg::l2_req_t     req
);

    l1_bus_pkg::l1_source_t last_src;
    l1_bus_pkg::l2_req_t    next_req;
    logic                   issue;
    logic                   grant_data;

    // The master still shows idle in the cycle of an issued request
    assign issue = master_idle && !req_valid && (if_pending || d_pending);

    // Alternate when both wait, otherwise serve whoever is waiting
    assign grant_data = d_pending && (!if_pending || (last_src == l1_bus_pkg::SRC_IFETCH));

    assign if_take = issue && !grant_data;
    assign d_take  = issue && grant_data;

    // Widen the fetch into a full word read
    always_comb begin
        if (grant_data) begin
            next_req.cmd = d_held;
            next_req.src = l1_bus_pkg::SRC_DATA;
        end else begin
            next_req.cmd.addr  = if_held.addr;
            next_req.cmd.we    = 1'b0;
            next_req.cmd.be    = '1;
            next_req.cmd.wdata = '0;
            next_req.src       = l1_bus_pkg::SRC_IFETCH;
        end
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
            // Fetch wins the first tie after reset
            last_src  <= l1_bus_pkg::SRC_DATA;
        end else begin
            req_valid <= issue;
            if (issue) begin
                last_src <= next_req.src;
            end
        end
    end

    // Issued request
    always_ff @(posedge clk) begin
        if (issue) begin
            req <= next_req;
        end
    end

    a_single_take : assert property (
        @(posedge clk) disable iff (rst)
        !(if_take && d_take)
    ) else $error("both ports granted in one cycle");

endmodule

// File: src/wishbone_master.sv
// Wishbone classic master that runs one single-word cycle per arbitrated request
`timescale 1ns/1ns

module wishbone_master (
    input  logic clk,
    input  logic rst,

    // Arbiter side
    input  logic                          req_valid,
    input  l1_bus_pkg::l2_req_t           req,
    output logic                          idle,

    // Router side
    output logic                          done,
    output l1_bus_pkg::l2_rsp_t           rsp,

    // Wishbone bus
    output logic [l1_bus_pkg::WB_ADR_W-1:0] wb_adr,
    output logic [l1_bus_pkg::DATA_W-1:0]   wb_dat_w,
    output logic [l1_bus_pkg::BE_W-1:0]     wb_sel,
    output logic                            wb_cyc,
    output logic                            wb_stb,
    output logic                            wb_we,
    input  logic [l1_bus_pkg::DATA_W-1:0]   wb_dat_r,
    input  logic                            wb_ack,
    input  logic                            wb_err
);

    typedef enum logic {
        ST_IDLE,
        ST_ACTIVE
    } state_t;

    state_t                 state;
    l1_bus_pkg::l1_source_t active_src;
    logic                   start;
    logic                   finish;

    assign idle   = (state == ST_IDLE);
    assign start  = idle && req_valid;
    // Slave terminates with either ack or err
    assign finish = (state == ST_ACTIVE) && (wb_ack || wb_err);

    // FSM and bus control
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            done   <= 1'b0;
        end else begin
            done <= finish;
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        state  <= ST_ACTIVE;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        // Fetches never write
                        wb_we  <= req.cmd.we && (req.src != l1_bus_pkg::SRC_IFETCH);
                    end
                end
                ST_ACTIVE: begin
                    if (finish) begin
                        state  <= ST_IDLE;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Address phase payload
    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr     <= req.cmd.addr[l1_bus_pkg::ADDR_W-1:2];
            wb_dat_w   <= req.cmd.wdata;
            wb_sel     <= req.cmd.be;
            active_src <= req.src;
        end
    end

    // Result capture, data is only meaningful on a good read
    always_ff @(posedge clk) begin
        if (finish) begin
            rsp.rdata <= (wb_err || wb_we) ? '0 : wb_dat_r;
            rsp.err   <= wb_err;
            rsp.src   <= active_src;
        end
    end

    a_stb_in_cyc : assert property (
        @(posedge clk) disable iff (rst)
        wb_stb |-> wb_cyc
    ) else $error("stb without cyc");

    // Arbiter must wait for idle
    a_no_req_when_active : assert property (
        @(posedge clk) disable iff (rst)
        req_valid |-> (state == ST_IDLE)
    ) else $error("request issued while bus cycle active");

endmodule

// File: src/l1_response_router.sv
// Routes the finished bus result as a one-cycle response to the requester named by its tag
`timescale 1ns/1ns

module l1_response_router (
    input  logic clk,
    input  logic rst,

    // From the bus master
    input  logic                      done,
    input  l1_bus_pkg::l2_rsp_t       rsp,

    // Instruction fetch port
    output logic                      if_rsp_valid,
    output l1_bus_pkg::port_rsp_t     if_rsp_data,

    // Data port
    output logic                      d_rsp_valid,
    output l1_bus_pkg::port_rsp_t     d_rsp_data
);

    logic to_if;
    logic to_d;

    assign to_if = done && (rsp.src == l1_bus_pkg::SRC_IFETCH);
    assign to_d  = done && (rsp.src == l1_bus_pkg::SRC_DATA);

    // Response pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            if_rsp_valid <= 1'b0;
            d_rsp_valid  <= 1'b0;
        end else begin
            if_rsp_valid <= to_if;
            d_rsp_valid  <= to_d;
        end
    end

    // Each port keeps its last response
    always_ff @(posedge clk) begin
        if (to_if) begin
            if_rsp_data.rdata <= rsp.rdata;
            if_rsp_data.err   <= rsp.err;
        end
        if (to_d) begin
            d_rsp_data.rdata <= rsp.rdata;
            d_rsp_data.err   <= rsp.err;
        end
    end

    a_one_port_at_a_time : assert property (
        @(posedge clk) disable iff (rst)
        !(if_rsp_valid && d_rsp_valid)
    ) else $error("response pulsed on both ports");

endmodule

// File: src/l1_to_wishbone.sv
// Top level joining the instruction and data request ports onto one Wishbone classic master
`timescale 1ns/1ns

module l1_to_wishbone (
    input  logic clk,
    input  logic rst,

    // Instruction fetch port
    input  logic                            ifetch_req,
    input  l1_bus_pkg::ifetch_req_t         ifetch_req_data,
    output logic                            ifetch_busy,
    output logic                            ifetch_rsp_valid,
    output l1_bus_pkg::port_rsp_t           ifetch_rsp_data,

    // Data port
    input  logic                            data_req,
    input  l1_bus_pkg::data_req_t           data_req_data,
    output logic                            data_busy,
    output logic                            data_rsp_valid,
    output l1_bus_pkg::port_rsp_t           data_rsp_data,

    // Wishbone
    output logic [l1_bus_pkg::WB_ADR_W-1:0] wb_adr,
    output logic [l1_bus_pkg::DATA_W-1:0]   wb_dat_w,
    output logic [l1_bus_pkg::BE_W-1:0]     wb_sel,
    output logic                            wb_cyc,
    output logic                            wb_stb,
    output logic                            wb_we,
    input  logic [l1_bus_pkg::DATA_W-1:0]   wb_dat_r,
    input  logic                            wb_ack,
    input  logic                            wb_err
);

    logic                    if_pending;
    logic                    if_take;
    l1_bus_pkg::ifetch_req_t if_held;
    logic                    d_pending;
    logic                    d_take;
    l1_bus_pkg::data_req_t   d_held;
    logic                    l2_valid;
    l1_bus_pkg::l2_req_t     l2_req;
    logic                    master_idle;
    logic                    master_done;
    l1_bus_pkg::l2_rsp_t     l2_rsp;

    l1_request_hold #(.REQ_T(l1_bus_pkg::ifetch_req_t)) u_ifetch_hold (
        .clk(clk), .rst(rst), .req(ifetch_req), .req_data(ifetch_req_data),
        .busy(ifetch_busy), .pending(if_pending), .held(if_held),
        .take(if_take), .rsp_valid(ifetch_rsp_valid)
    );

    l1_request_hold #(.REQ_T(l1_bus_pkg::data_req_t)) u_data_hold (
        .clk(clk), .rst(rst), .req(data_req), .req_data(data_req_data),
        .busy(data_busy), .pending(d_pending), .held(d_held),
        .take(d_take), .rsp_valid(data_rsp_valid)
    );

    l1_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .if_pending(if_pending), .if_held(if_held), .if_take(if_take),
        .d_pending(d_pending), .d_held(d_held), .d_take(d_take),
        .master_idle(master_idle), .req_valid(l2_valid), .req(l2_req)
    );

    wishbone_master u_wishbone_master (
        .clk(clk), .rst(rst),
        .req_valid(l2_valid), .req(l2_req), .idle(master_idle),
        .done(master_done), .rsp(l2_rsp),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .wb_err(wb_err)
    );

    l1_response_router u_response_router (
        .clk(clk), .rst(rst), .done(master_done), .rsp(l2_rsp),
        .if_rsp_valid(ifetch_rsp_valid), .if_rsp_data(ifetch_rsp_data),
        .d_rsp_valid(data_rsp_valid), .d_rsp_data(data_rsp_data)
    );

endmodule

// File: tb/wb_slave_model.sv
// Behavioural Wishbone classic slave with word memory, random wait states, a fault region and a log
`timescale 1ns/1ns

module wb_slave_model (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [l1_bus_pkg::WB_ADR_W-1:0] wb_adr,
    input  logic [l1_bus_pkg::DATA_W-1:0]   wb_dat_w,
    input  logic [l1_bus_pkg::BE_W-1:0]     wb_sel,
    input  logic                            wb_cyc,
    input  logic                            wb_stb,
    input  logic                            wb_we,
    output logic [l1_bus_pkg::DATA_W-1:0]   wb_dat_r,
    output logic                            wb_ack,
    output logic                            wb_err
);

    // Word addresses below this belong to the instruction window of the tests
    localparam int IFETCH_WORDS = 64;
    localparam int LOG_DEPTH    = 256;

    logic [l1_bus_pkg::DATA_W-1:0] mem [0:255];
    l1_bus_pkg::l1_source_t        log_src [0:LOG_DEPTH-1];
    int                            log_count;
    int                            seed;
    int                            wait_left;
    logic                          in_access;

    initial begin
        seed = 32'h32d9;
        for (int i = 0; i < 256; i++) begin
            mem[i] = i ^ 32'hA5A5_0000;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            wb_err    <= 1'b0;
            wb_dat_r  <= '0;
            in_access <= 1'b0;
            wait_left <= 0;
            log_count <= 0;
        end else begin
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
            // Skip the cycle where the master still sees our own ack or err
            if (wb_cyc && wb_stb && !wb_ack && !wb_err) begin
                if (!in_access) begin
                    in_access <= 1'b1;
                    wait_left <= $unsigned($random(seed)) % 4;
                end else if (wait_left != 0) begin
                    wait_left <= wait_left - 1;
                end else begin
                    in_access <= 1'b0;
                    if (wb_adr[29:28] == 2'b11) begin
                        wb_err   <= 1'b1;
                        wb_dat_r <= '0;
                    end else begin
                        wb_ack <= 1'b1;
                        if (wb_we) begin
                            for (int b = 0; b < l1_bus_pkg::BE_W; b++) begin
                                if (wb_sel[b]) begin
                                    mem[wb_adr[7:0]][8*b +: 8] <= wb_dat_w[8*b +: 8];
                                end
                            end
                        end else begin
                            wb_dat_r <= mem[wb_adr[7:0]];
                        end
                    end
                    // Record which requester this bus cycle came from
                    if (log_count < LOG_DEPTH) begin
                        if (!wb_we && (wb_adr < IFETCH_WORDS)) begin
                            log_src[log_count] <= l1_bus_pkg::SRC_IFETCH;
                        end else begin
                            log_src[log_count] <= l1_bus_pkg::SRC_DATA;
                        end
                        log_count <= log_count + 1;
                    end
                end
            end
        end
    end

endmodule

// File: tb/tb_l1_to_wishbone.sv
// Testbench top that runs directed tests on both L1 ports against a Wishbone slave model
`timescale 1ns/1ns

module tb_l1_to_wishbone;

    // About 40 transactions of up to 12 cycles each, with plenty of margin
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] IF_BASE        = 32'h0000_0000;
    localparam logic [31:0] D_BASE         = 32'h0000_0100;
    localparam logic [31:0] FAULT_BASE     = 32'hC000_0000;

    logic                                clk;
    logic                                rst;
    logic                                ifetch_req;
    l1_bus_pkg::ifetch_req_t             ifetch_req_data;
    logic                                ifetch_busy;
    logic                                ifetch_rsp_valid;
    l1_bus_pkg::port_rsp_t               ifetch_rsp_data;
    logic                                data_req;
    l1_bus_pkg::data_req_t               data_req_data;
    logic                                data_busy;
    logic                                data_rsp_valid;
    l1_bus_pkg::port_rsp_t               data_rsp_data;
    logic [l1_bus_pkg::WB_ADR_W-1:0]     wb_adr;
    logic [l1_bus_pkg::DATA_W-1:0]       wb_dat_w;
    logic [l1_bus_pkg::BE_W-1:0]         wb_sel;
    logic                                wb_cyc;
    logic                                wb_stb;
    logic                                wb_we;
    logic [l1_bus_pkg::DATA_W-1:0]       wb_dat_r;
    logic                                wb_ack;
    logic                                wb_err;

    // Expected memory contents tracking every good write
    logic [31:0] mem_model [0:255];
    int          seed;
    int          cycle_count;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    l1_to_wishbone u_l1_to_wishbone (
        .clk(clk), .rst(rst),
        .ifetch_req(ifetch_req), .ifetch_req_data(ifetch_req_data),
        .ifetch_busy(ifetch_busy), .ifetch_rsp_valid(ifetch_rsp_valid),
        .ifetch_rsp_data(ifetch_rsp_data),
        .data_req(data_req), .data_req_data(data_req_data),
        .data_busy(data_busy), .data_rsp_valid(data_rsp_valid),
        .data_rsp_data(data_rsp_data),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .wb_err(wb_err)
    );

    wb_slave_model u_wb_slave_model (
        .clk(clk), .rst(rst),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .wb_err(wb_err)
    );

    function automatic logic [7:0] word_index(input logic [31:0] addr);
        return addr[9:2];
    endfunction

    function automatic logic in_fault_region(input logic [31:0] addr);
        return addr[31:30] == 2'b11;
    endfunction

    function automatic l1_bus_pkg::port_rsp_t expected_read(input logic [31:0] addr);
        l1_bus_pkg::port_rsp_t r;
        r.err   = in_fault_region(addr);
        r.rdata = r.err ? 32'h0 : mem_model[word_index(addr)];
        return r;
    endfunction

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic expect_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_port_rsp(input string what, input l1_bus_pkg::port_rsp_t got,
                                  input l1_bus_pkg::port_rsp_t exp);
        if (got !== exp) begin
            report_error($sformatf("%s: got rdata %h err %b, expected rdata %h err %b",
                                   what, got.rdata, got.err, exp.rdata, exp.err));
        end
    endtask

    task automatic check_wb_order(input int index, input l1_bus_pkg::l1_source_t exp);
        if (index >= u_wb_slave_model.log_count) begin
            report_error($sformatf("bus log has no entry %0d", index));
        end else if (u_wb_slave_model.log_src[index] !== exp) begin
            report_error($sformatf("bus log entry %0d: got source %0d, expected %0d",
                                   index, u_wb_slave_model.log_src[index], exp));
        end
    endtask

    // Entered at a falling edge; busy drops at the edge after the pulse, so a strobe may go then
    task automatic ifetch_transfer(input logic [31:0] addr,
                                   output l1_bus_pkg::port_rsp_t rsp);
        while (ifetch_busy && !ifetch_rsp_valid) @(negedge clk);
        @(posedge clk);
        ifetch_req           <= 1'b1;
        ifetch_req_data.addr <= addr;
        @(posedge clk);
        ifetch_req <= 1'b0;
        @(negedge clk);
        while (!ifetch_rsp_valid) begin
            expect_level("ifetch busy while waiting", ifetch_busy, 1'b1);
            @(negedge clk);
        end
        expect_level("ifetch busy at response", ifetch_busy, 1'b1);
        rsp = ifetch_rsp_data;
    endtask

    task automatic data_transfer(input l1_bus_pkg::data_req_t req,
                                 output l1_bus_pkg::port_rsp_t rsp);
        while (data_busy && !data_rsp_valid) @(negedge clk);
        @(posedge clk);
        data_req      <= 1'b1;
        data_req_data <= req;
        @(posedge clk);
        data_req <= 1'b0;
        @(negedge clk);
        while (!data_rsp_valid) begin
            expect_level("data busy while waiting", data_busy, 1'b1);
            @(negedge clk);
        end
        expect_level("data busy at response", data_busy, 1'b1);
        rsp = data_rsp_data;
    endtask

    task automatic fetch_word(input logic [31:0] addr);
        l1_bus_pkg::port_rsp_t got;
        ifetch_transfer(addr, got);
        check_port_rsp($sformatf("fetch %h", addr), got, expected_read(addr));
    endtask

    task automatic read_word(input logic [31:0] addr);
        l1_bus_pkg::data_req_t req;
        l1_bus_pkg::port_rsp_t got;
        req.addr  = addr;
        req.we    = 1'b0;
        req.be    = 4'hF;
        req.wdata = '0;
        data_transfer(req, got);
        check_port_rsp($sformatf("data read %h", addr), got, expected_read(addr));
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata);
        l1_bus_pkg::data_req_t req;
        l1_bus_pkg::port_rsp_t got;
        l1_bus_pkg::port_rsp_t exp;
        req.addr  = addr;
        req.we    = 1'b1;
        req.be    = be;
        req.wdata = wdata;
        data_transfer(req, got);
        // Writes return no data
        exp.rdata = '0;
        exp.err   = in_fault_region(addr);
        check_port_rsp($sformatf("data write %h", addr), got, exp);
        if (!exp.err) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem_model[word_index(addr)][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
    endtask

    task automatic check_idle_outputs(input string phase);
        expect_level({"wb_cyc ", phase}, wb_cyc, 1'b0);
        expect_level({"wb_stb ", phase}, wb_stb, 1'b0);
        expect_level({"ifetch_busy ", phase}, ifetch_busy, 1'b0);
        expect_level({"data_busy ", phase}, data_busy, 1'b0);
        expect_level({"ifetch_rsp_valid ", phase}, ifetch_rsp_valid, 1'b0);
        expect_level({"data_rsp_valid ", phase}, data_rsp_valid, 1'b0);
    endtask

    // Reset is sampled on five rising edges
    task automatic reset_state_checks();
        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            check_idle_outputs("during reset");
            @(posedge clk);
        end
        rst <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs("after reset");
        end
    endtask

    task automatic fetch_reads();
        for (int i = 0; i < 4; i++) begin
            fetch_word(IF_BASE + i * 20);
        end
    endtask

    task automatic write_then_read();
        logic [31:0] addr;
        for (int i = 0; i < 4; i++) begin
            addr = D_BASE + i * 28;
            write_word(addr, $random(seed), $random(seed));
            read_word(addr);
        end
    endtask

    // A tie goes to the port that was not served last
    task automatic both_ports_at_once();
        int                     start;
        logic [31:0]            wdata;
        l1_bus_pkg::l1_source_t last_src;
        l1_bus_pkg::l1_source_t exp_order [$];
        start = u_wb_slave_model.log_count;
        // The previous test ended on the data port
        last_src = l1_bus_pkg::SRC_DATA;
        for (int r = 0; r < 6; r++) begin
            // A lone fetch halfway hands the next ties to the data port
            if (r == 3) begin
                fetch_word(IF_BASE + 32'h60);
                exp_order.push_back(l1_bus_pkg::SRC_IFETCH);
                last_src = l1_bus_pkg::SRC_IFETCH;
            end
            wdata = $random(seed);
            fork
                fetch_word(IF_BASE + 32'h80 + r * 4);
                begin
                    if (r % 2 == 0) begin
                        write_word(D_BASE + 32'h100 + r * 4, 4'hF, wdata);
                    end else begin
                        read_word(D_BASE + 32'h100 + (r - 1) * 4);
                    end
                end
            join
            if (last_src == l1_bus_pkg::SRC_DATA) begin
                exp_order.push_back(l1_bus_pkg::SRC_IFETCH);
                exp_order.push_back(l1_bus_pkg::SRC_DATA);
                last_src = l1_bus_pkg::SRC_DATA;
            end else begin
                exp_order.push_back(l1_bus_pkg::SRC_DATA);
                exp_order.push_back(l1_bus_pkg::SRC_IFETCH);
                last_src = l1_bus_pkg::SRC_IFETCH;
            end
        end
        foreach (exp_order[k]) begin
            check_wb_order(start + k, exp_order[k]);
        end
    endtask

    task automatic fault_region();
        l1_bus_pkg::port_rsp_t got;
        l1_bus_pkg::port_rsp_t data_before;
        data_before = data_rsp_data;
        ifetch_transfer(FAULT_BASE + 32'h40, got);
        check_port_rsp("fault fetch", got, expected_read(FAULT_BASE + 32'h40));
        expect_level("data_rsp_valid on fault fetch", data_rsp_valid, 1'b0);
        check_port_rsp("data port untouched by fault fetch", data_rsp_data, data_before);
        read_word(FAULT_BASE + 32'h104);
        write_word(FAULT_BASE + 32'h108, 4'hF, $random(seed));
        // Word with the same low address bits as the faulting write stays unchanged
        read_word(32'h0000_0108);
    endtask

    task automatic back_pressure();
        logic [31:0] addr;
        for (int i = 0; i < 4; i++) begin
            addr = D_BASE + 32'h200 + i * 8;
            write_word(addr, $random(seed), $random(seed));
            read_word(addr);
            fetch_word(IF_BASE + 32'hC0 + i * 4);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        seed            = 32'h32d9;
        rst             = 1'b1;
        ifetch_req      = 1'b0;
        ifetch_req_data = '0;
        data_req        = 1'b0;
        data_req_data   = '0;
        for (int i = 0; i < 256; i++) begin
            mem_model[i] = i ^ 32'hA5A5_0000;
        end
        reset_state_checks();
        fetch_reads();
        write_then_read();
        both_ports_at_once();
        fault_region();
        back_pressure();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: tb.f
src/l1_bus_pkg.sv
src/l1_request_hold.sv
src/l1_arbiter.sv
src/wishbone_master.sv
src/l1_response_router.sv
src/l1_to_wishbone.sv
tb/wb_slave_model.sv
tb/tb_l1_to_wishbone.sv
